// File: verilog/vldu_defs.svh
`ifndef VLDU_DEFS_SVH
`define VLDU_DEFS_SVH

// Number of lanes behind the load unit
`define VLDU_NR_LANES 2

// Bytes in one lane word of the VRF
`define VLDU_LANE_BYTES 8

// One read beat covers exactly one full VRF word
`define VLDU_BEAT_BYTES (`VLDU_NR_LANES * `VLDU_LANE_BYTES)

// In-flight instructions between accept and commit
`define VLDU_INSN_DEPTH 4

// Words waiting for lane grants
`define VLDU_RESULT_DEPTH 2

// Per-lane words in one vector register, stride of vd in the lane address
`define VLDU_REG_WORDS 8

`endif

// File: verilog/vldu_pkg.sv
`include "vldu_defs.svh"

package vldu_pkg;

  // Instruction id, unique while in flight
  typedef logic [1:0] vid_t;
  // Vector register number
  typedef logic [4:0] vreg_t;
  // Vector length in elements
  typedef logic [7:0] vl_t;
  // Element width code, 0..3 for 8..64 bit elements
  typedef logic [1:0] vsew_t;
  // Byte count, large enough for vl shifted by the widest element
  typedef logic [10:0] vbytes_t;
  // Lane word address in the VRF
  typedef logic [7:0] vaddr_t;

  typedef logic [`VLDU_LANE_BYTES*8-1:0] elen_t;
  typedef logic [`VLDU_LANE_BYTES-1:0]   strb_t;
  typedef logic [`VLDU_BEAT_BYTES*8-1:0] beat_t;

  // Load request from the sequencer
  typedef struct packed {
    vid_t  id;
    vreg_t vd;
    vl_t   vl;
    vsew_t vsew;
  } insn_t;

  // One VRF word on its way to the lanes
  typedef struct packed {
    vid_t                         id;
    vaddr_t                       addr;
    elen_t [`VLDU_NR_LANES-1:0]   wdata;
    strb_t [`VLDU_NR_LANES-1:0]   be;
    // Final word of the instruction
    logic                         last;
  } result_t;

endpackage

// File: verilog/vldu_insn_queue.sv
`timescale 1ns/1ps
`include "vldu_defs.svh"

module vldu_insn_queue (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Sequencer side
  input  vldu_pkg::insn_t insn_i,
  input  logic            insn_valid_i,
  output logic            insn_ready_o,
  // Execute stage side
  output vldu_pkg::insn_t issue_insn_o,
  output logic            issue_valid_o,
  input  logic            issue_done_i,
  // Final word of the oldest instruction left the result queue
  input  logic            commit_i
);

  import vldu_pkg::*;

  localparam int unsigned PNT_W = $clog2(`VLDU_INSN_DEPTH);
  localparam int unsigned CNT_W = $clog2(`VLDU_INSN_DEPTH + 1);

  // Instruction storage, payload only
  insn_t insn_mem [`VLDU_INSN_DEPTH];

  // Slot pointers for accept and issue, commit is tracked by its count
  logic [PNT_W-1:0] accept_pnt_q;
  logic [PNT_W-1:0] issue_pnt_q;

  // Entries still waiting to issue, and entries not yet committed
  logic [CNT_W-1:0] issue_cnt_q, issue_cnt_d;
  logic [CNT_W-1:0] commit_cnt_q, commit_cnt_d;

  logic accept;

  // Room as long as fewer than four loads sit between accept and commit
  assign insn_ready_o  = (commit_cnt_q != CNT_W'(`VLDU_INSN_DEPTH));
  assign accept        = insn_valid_i && insn_ready_o;
  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_insn_o  = insn_mem[issue_pnt_q];

  always_comb begin
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    // Accept and issue can meet in the same cycle
    case ({accept, issue_done_i})
      2'b10:   issue_cnt_d = issue_cnt_q + 1'b1;
      2'b01:   issue_cnt_d = issue_cnt_q - 1'b1;
      default: issue_cnt_d = issue_cnt_q;
    endcase
    // Same for accept against commit
    case ({accept, commit_i})
      2'b10:   commit_cnt_d = commit_cnt_q + 1'b1;
      2'b01:   commit_cnt_d = commit_cnt_q - 1'b1;
      default: commit_cnt_d = commit_cnt_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      // Depth is a power of two, pointers wrap by themselves
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
    end
  end

  // Write the accepted load into its slot
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_mem[accept_pnt_q] <= insn_i;
    end
  end

endmodule

// File: verilog/vldu_beat_unpack.sv
`timescale 1ns/1ps
`include "vldu_defs.svh"

module vldu_beat_unpack (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Instruction at the issue pointer
  input  vldu_pkg::insn_t   issue_insn_i,
  input  logic              issue_valid_i,
  output logic              issue_done_o,
  // Read data from memory
  input  vldu_pkg::beat_t   r_data_i,
  input  logic              r_valid_i,
  output logic              r_ready_o,
  // Result queue side
  input  logic              full_i,
  output logic              push_o,
  output vldu_pkg::result_t push_data_o
);

  import vldu_pkg::*;

  localparam int unsigned LANE_BITS = `VLDU_LANE_BYTES * 8;

  // Set once the current instruction has consumed its first beat
  logic    active_q;
  vbytes_t rem_q;
  vaddr_t  word_q;

  vbytes_t rem_cur;
  vbytes_t rem_next;
  vaddr_t  word_cur;
  logic    last_word;
  logic    beat_fire;

  // A fresh instruction starts from vl scaled to bytes and word zero
  assign rem_cur  = active_q ? rem_q : (vbytes_t'(issue_insn_i.vl) << issue_insn_i.vsew);
  assign word_cur = active_q ? word_q : '0;

  // One beat retires a full VRF word, floored at zero
  assign rem_next  = (rem_cur > vbytes_t'(`VLDU_BEAT_BYTES)) ?
                     rem_cur - vbytes_t'(`VLDU_BEAT_BYTES) : '0;
  assign last_word = (rem_next == '0);

  // Beat is taken only with a load to feed and space downstream
  assign r_ready_o    = r_valid_i && issue_valid_i && !full_i;
  assign beat_fire    = r_ready_o;
  assign push_o       = beat_fire;
  assign issue_done_o = beat_fire && last_word;

  always_comb begin
    push_data_o.id   = issue_insn_i.id;
    // Register base plus word offset inside the register group
    push_data_o.addr = vaddr_t'(vaddr_t'(issue_insn_i.vd) * `VLDU_REG_WORDS + word_cur);
    push_data_o.last = last_word;
    for (int l = 0; l < `VLDU_NR_LANES; l++) begin
      // Sequential mapping, lane l owns beat bytes 8l to 8l+7
      push_data_o.wdata[l] = r_data_i[l*LANE_BITS +: LANE_BITS];
      for (int b = 0; b < `VLDU_LANE_BYTES; b++) begin
        // Bytes past the end of the vector stay disabled
        push_data_o.be[l][b] = (vbytes_t'(l * `VLDU_LANE_BYTES + b) < rem_cur);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      rem_q    <= '0;
      word_q   <= '0;
    end else if (beat_fire) begin
      if (last_word) begin
        // Next load reloads its own byte count
        active_q <= 1'b0;
        rem_q    <= '0;
        word_q   <= '0;
      end else begin
        active_q <= 1'b1;
        rem_q    <= rem_next;
        word_q   <= word_cur + 1'b1;
      end
    end
  end

endmodule

// File: verilog/vldu_result_queue.sv
`timescale 1ns/1ps
`include "vldu_defs.svh"

module vldu_result_queue (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Execute stage side
  input  logic                                   push_i,
  input  vldu_pkg::result_t                      push_data_i,
  output logic                                   full_o,
  // Lane side
  output logic             [`VLDU_NR_LANES-1:0]  lane_req_o,
  output vldu_pkg::vid_t   [`VLDU_NR_LANES-1:0]  lane_id_o,
  output vldu_pkg::vaddr_t [`VLDU_NR_LANES-1:0]  lane_addr_o,
  output vldu_pkg::elen_t  [`VLDU_NR_LANES-1:0]  lane_wdata_o,
  output vldu_pkg::strb_t  [`VLDU_NR_LANES-1:0]  lane_be_o,
  input  logic             [`VLDU_NR_LANES-1:0]  lane_gnt_i,
  // Completion
  output logic                                   commit_o,
  output logic                                   done_o,
  output vldu_pkg::vid_t                         done_id_o
);

  import vldu_pkg::*;

  localparam int unsigned PNT_W = $clog2(`VLDU_RESULT_DEPTH);
  localparam int unsigned CNT_W = $clog2(`VLDU_RESULT_DEPTH + 1);

  result_t entry_q [`VLDU_RESULT_DEPTH];

  // Lanes that still owe a grant, per entry
  logic [`VLDU_RESULT_DEPTH-1:0][`VLDU_NR_LANES-1:0] pend_q, pend_d;

  logic [PNT_W-1:0] wr_pnt_q;
  logic [PNT_W-1:0] rd_pnt_q;
  logic [CNT_W-1:0] cnt_q, cnt_d;

  result_t head;
  logic    pop;
  logic    done_q;
  vid_t    done_id_q;

  assign head   = entry_q[rd_pnt_q];
  assign full_o = (cnt_q == CNT_W'(`VLDU_RESULT_DEPTH));

  // Head entry goes to every lane at once
  always_comb begin
    for (int l = 0; l < `VLDU_NR_LANES; l++) begin
      lane_req_o[l]   = pend_q[rd_pnt_q][l];
      lane_id_o[l]    = head.id;
      lane_addr_o[l]  = head.addr;
      lane_wdata_o[l] = head.wdata[l];
      lane_be_o[l]    = head.be[l];
    end
  end

  always_comb begin
    pend_d = pend_q;
    // Granted lanes drop their request next cycle
    pend_d[rd_pnt_q] = pend_q[rd_pnt_q] & ~lane_gnt_i;
    // Pop as soon as the last outstanding lane is granted
    pop = (cnt_q != '0) && (pend_d[rd_pnt_q] == '0);
    // New word requests every lane
    if (push_i) begin
      pend_d[wr_pnt_q] = '1;
    end
    case ({push_i, pop})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q   <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
      done_q   <= 1'b0;
    end else begin
      pend_q <= pend_d;
      cnt_q  <= cnt_d;
      if (push_i) begin
        wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      // Final word of a load fully written
      done_q <= pop && head.last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      entry_q[wr_pnt_q] <= push_data_i;
    end
    if (pop) begin
      done_id_q <= head.id;
    end
  end

  // One pulse frees the decode entry and reports completion
  assign done_o    = done_q;
  assign commit_o  = done_q;
  assign done_id_o = done_id_q;

endmodule

// File: verilog/vldu_top.sv
`timescale 1ns/1ps
`include "vldu_defs.svh"

module vldu_top (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Sequencer side
  input  vldu_pkg::insn_t                        insn_i,
  input  logic                                   insn_valid_i,
  output logic                                   insn_ready_o,
  // Memory read data
  input  vldu_pkg::beat_t                        r_data_i,
  input  logic                                   r_valid_i,
  output logic                                   r_ready_o,
  // Lane write ports
  output logic             [`VLDU_NR_LANES-1:0]  lane_req_o,
  output vldu_pkg::vid_t   [`VLDU_NR_LANES-1:0]  lane_id_o,
  output vldu_pkg::vaddr_t [`VLDU_NR_LANES-1:0]  lane_addr_o,
  output vldu_pkg::elen_t  [`VLDU_NR_LANES-1:0]  lane_wdata_o,
  output vldu_pkg::strb_t  [`VLDU_NR_LANES-1:0]  lane_be_o,
  input  logic             [`VLDU_NR_LANES-1:0]  lane_gnt_i,
  // Completion
  output logic                                   done_o,
  output vldu_pkg::vid_t                         done_id_o
);

  import vldu_pkg::*;

  // Decode to execute
  insn_t   issue_insn;
  logic    issue_valid;
  logic    issue_done;
  // Execute to result
  logic    push;
  result_t push_data;
  logic    full;
  // Result back to decode
  logic    commit;

  vldu_insn_queue u_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .insn_ready_o  (insn_ready_o),
    .issue_insn_o  (issue_insn),
    .issue_valid_o (issue_valid),
    .issue_done_i  (issue_done),
    .commit_i      (commit)
  );

  vldu_beat_unpack u_beat_unpack (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_insn_i  (issue_insn),
    .issue_valid_i (issue_valid),
    .issue_done_o  (issue_done),
    .r_data_i      (r_data_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .full_i        (full),
    .push_o        (push),
    .push_data_o   (push_data)
  );

  vldu_result_queue u_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_data_i  (push_data),
    .full_o       (full),
    .lane_req_o   (lane_req_o),
    .lane_id_o    (lane_id_o),
    .lane_addr_o  (lane_addr_o),
    .lane_wdata_o (lane_wdata_o),
    .lane_be_o    (lane_be_o),
    .lane_gnt_i   (lane_gnt_i),
    .commit_o     (commit),
    .done_o       (done_o),
    .done_id_o    (done_id_o)
  );

endmodule

// File: verif/vldu_properties.sv
`timescale 1ns/1ps
`include "vldu_defs.svh"

module vldu_properties (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       insn_ready_o,
  input logic                       r_valid_i,
  input logic                       r_ready_o,
  input logic [`VLDU_NR_LANES-1:0]  lane_req_o,
  input logic [`VLDU_NR_LANES-1:0]  lane_gnt_i,
  input logic                       done_o,
  input vldu_pkg::vid_t             done_id_o
);

  // Words each lane still owes a grant for, counted from the port activity
  logic [`VLDU_NR_LANES-1:0][2:0] owed_q;
  logic                           room;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owed_q <= '0;
    end else begin
      for (int l = 0; l < `VLDU_NR_LANES; l++) begin
        owed_q[l] <= owed_q[l] + 3'(r_ready_o) - 3'(lane_req_o[l] && lane_gnt_i[l]);
      end
    end
  end

  // Result queue has a free entry while no lane owes two words
  always_comb begin
    room = 1'b1;
    for (int l = 0; l < `VLDU_NR_LANES; l++) begin
      if (owed_q[l] >= 3'(`VLDU_RESULT_DEPTH)) begin
        room = 1'b0;
      end
    end
  end

  // Beat only taken while memory offers one and a result entry is free
  a_ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_ready_o |-> r_valid_i && room)
    else $error("r_ready_o high without r_valid_i or with the result queue full");

  // Request held until its lane grants it
  for (genvar l = 0; l < `VLDU_NR_LANES; l++) begin : g_lane
    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      lane_req_o[l] && !lane_gnt_i[l] |=> lane_req_o[l])
      else $error("lane %0d dropped its request before a grant", l);
  end

  // Back to back pulses only for two different loads
  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o || (done_id_o != $past(done_id_o)))
    else $error("done_o held high for the same load id");

  // First edge out of reset sees an idle unit
  a_reset_idle: assert property (@(posedge clk_i)
    !$past(rst_ni) && rst_ni |-> insn_ready_o && !r_ready_o && (lane_req_o == '0) && !done_o)
    else $error("unit not idle right after reset");

endmodule

bind vldu_top vldu_properties u_vldu_properties (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .insn_ready_o (insn_ready_o),
  .r_valid_i    (r_valid_i),
  .r_ready_o    (r_ready_o),
  .lane_req_o   (lane_req_o),
  .lane_gnt_i   (lane_gnt_i),
  .done_o       (done_o),
  .done_id_o    (done_id_o)
);

// File: verif/tb_vldu.sv
`timescale 1ns/1ps
`include "vldu_defs.svh"

module tb_vldu;

  import vldu_pkg::*;

  localparam int NR_ROWS      = 10;
  localparam int MAX_WORDS    = 64;
  localparam int INSN_TIMEOUT = 2000;
  localparam int DONE_TIMEOUT = 5000;

  // One load with its grant behavior and expected word count
  typedef struct packed {
    insn_t      insn;
    logic       stall;
    logic [7:0] words;
  } row_t;

  logic                        clk_i = 1'b0;
  logic                        rst_ni;
  insn_t                       insn_i;
  logic                        insn_valid_i;
  logic                        insn_ready_o;
  beat_t                       r_data_i;
  logic                        r_valid_i;
  logic                        r_ready_o;
  logic   [`VLDU_NR_LANES-1:0] lane_req_o;
  vid_t   [`VLDU_NR_LANES-1:0] lane_id_o;
  vaddr_t [`VLDU_NR_LANES-1:0] lane_addr_o;
  elen_t  [`VLDU_NR_LANES-1:0] lane_wdata_o;
  strb_t  [`VLDU_NR_LANES-1:0] lane_be_o;
  logic   [`VLDU_NR_LANES-1:0] lane_gnt_i;
  logic                        done_o;
  vid_t                        done_id_o;

  row_t rows [NR_ROWS];
  // Expected words in the order beats are consumed
  int                          exp_row  [MAX_WORDS];
  vaddr_t                      exp_addr [MAX_WORDS];
  logic [`VLDU_BEAT_BYTES-1:0] exp_be   [MAX_WORDS];
  int                          last_idx [NR_ROWS];
  int                          total_words;
  // Beats as they were taken by the DUT
  beat_t                       beat_log [MAX_WORDS];
  int                          beat_cnt;
  int                          wr_cnt [`VLDU_NR_LANES];
  int                          done_cnt;
  int                          err_cnt;
  int                          chk_cnt;
  integer                      seed;
  logic                        stim_on;
  logic                        saw_full;
  logic                        aborted;

  vldu_top u_vldu_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_i       (insn_i),
    .insn_valid_i (insn_valid_i),
    .insn_ready_o (insn_ready_o),
    .r_data_i     (r_data_i),
    .r_valid_i    (r_valid_i),
    .r_ready_o    (r_ready_o),
    .lane_req_o   (lane_req_o),
    .lane_id_o    (lane_id_o),
    .lane_addr_o  (lane_addr_o),
    .lane_wdata_o (lane_wdata_o),
    .lane_be_o    (lane_be_o),
    .lane_gnt_i   (lane_gnt_i),
    .done_o       (done_o),
    .done_id_o    (done_id_o)
  );

  always #10 clk_i = ~clk_i;

  function automatic void set_row(input int r, input int id, input int vd, input int vl,
                                  input int vsew, input logic stall, input int words);
    rows[r].insn.id   = vid_t'(id);
    rows[r].insn.vd   = vreg_t'(vd);
    rows[r].insn.vl   = vl_t'(vl);
    rows[r].insn.vsew = vsew_t'(vsew);
    rows[r].stall     = stall;
    rows[r].words     = 8'(words);
  endfunction

  function automatic void load_table();
    // Long stalled load keeps four loads in flight
    set_row(0, 0, 2, 32, 3, 1'b1, 16);
    // Exactly one full word
    set_row(1, 1, 5, 16, 0, 1'b0, 1);
    // Partial last word
    set_row(2, 2, 7, 5, 2, 1'b0, 2);
    // Zero padded enables
    set_row(3, 3, 1, 3, 1, 1'b0, 1);
    set_row(4, 0, 9, 4, 3, 1'b1, 2);
    set_row(5, 1, 12, 1, 0, 1'b0, 1);
    set_row(6, 2, 3, 9, 1, 1'b1, 2);
    set_row(7, 3, 30, 7, 2, 1'b0, 2);
    // Several 64-bit words back to back
    set_row(8, 0, 4, 12, 3, 1'b0, 6);
    set_row(9, 1, 6, 17, 0, 1'b0, 2);
  endfunction

  function automatic void build_expected();
    int k;
    int bytes;
    k = 0;
    for (int r = 0; r < NR_ROWS; r++) begin
      // Byte count is vl scaled by the element width
      bytes = int'(rows[r].insn.vl) << rows[r].insn.vsew;
      for (int w = 0; w < int'(rows[r].words); w++) begin
        exp_row[k]  = r;
        exp_addr[k] = vaddr_t'(int'(rows[r].insn.vd) * `VLDU_REG_WORDS + w);
        for (int b = 0; b < `VLDU_BEAT_BYTES; b++) begin
          exp_be[k][b] = ((w * `VLDU_BEAT_BYTES + b) < bytes);
        end
        k++;
      end
      last_idx[r] = k - 1;
    end
    total_words = k;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    chk_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  // One lane write against the expected word at that lane's position
  task automatic check_write(input int l);
    int k;
    int r;
    k = wr_cnt[l];
    if (k >= total_words) begin
      report_failure($sformatf("lane %0d got a write beyond the last expected word", l));
    end else begin
      r = exp_row[k];
      check_value($sformatf("row%0d word%0d lane%0d id", r, k, l),
                  64'(rows[r].insn.id), 64'(lane_id_o[l]));
      check_value($sformatf("row%0d word%0d lane%0d addr", r, k, l),
                  64'(exp_addr[k]), 64'(lane_addr_o[l]));
      // Lane l owns beat bytes 8l to 8l+7
      check_value($sformatf("row%0d word%0d lane%0d wdata", r, k, l),
                  beat_log[k][l*64 +: 64], lane_wdata_o[l]);
      check_value($sformatf("row%0d word%0d lane%0d be", r, k, l),
                  64'(exp_be[k][l*8 +: 8]), 64'(lane_be_o[l]));
    end
  endtask

  task automatic check_done(input int done_words);
    int r;
    r = done_cnt;
    if (r >= NR_ROWS) begin
      report_failure("done_o pulsed after every load had already completed");
    end else begin
      check_value($sformatf("row%0d done id", r), 64'(rows[r].insn.id), 64'(done_id_o));
      // Done comes one cycle after the final grant of the last word
      check_value($sformatf("row%0d words written at done", r),
                  64'(last_idx[r] + 1), 64'(done_words));
    end
    done_cnt++;
  endtask

  task automatic offer_insn(input int r);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    @(negedge clk_i);
    insn_i       = rows[r].insn;
    insn_valid_i = 1'b1;
    while (!taken && waited < INSN_TIMEOUT) begin
      @(posedge clk_i);
      if (insn_ready_o) begin
        taken = 1'b1;
      end else begin
        // Four loads between accept and commit
        saw_full = 1'b1;
        waited++;
      end
    end
    if (!taken) begin
      report_failure($sformatf("timeout: load of row %0d was never accepted", r));
      aborted = 1'b1;
    end
  endtask

  // Outputs sampled at the rising edge, before the DUT updates
  always @(posedge clk_i) begin : sample_outputs
    int done_words;
    if (rst_ni) begin
      done_words = (wr_cnt[0] < wr_cnt[1]) ? wr_cnt[0] : wr_cnt[1];
      if (done_o) begin
        check_done(done_words);
      end
      if (r_ready_o) begin
        // Two words waiting for grants means the queue is full
        if (beat_cnt >= done_words + `VLDU_RESULT_DEPTH) begin
          report_failure("beat consumed while two words were still waiting for grants");
        end
        if (beat_cnt < MAX_WORDS) begin
          beat_log[beat_cnt] = r_data_i;
        end
        beat_cnt++;
      end
      for (int l = 0; l < `VLDU_NR_LANES; l++) begin
        if (lane_req_o[l] && lane_gnt_i[l]) begin
          check_write(l);
          wr_cnt[l]++;
        end
      end
    end
  end

  // Memory and lane models, driven on the falling edge
  always @(negedge clk_i) begin : drive_inputs
    int k;
    if (stim_on) begin
      r_valid_i = (($random(seed) & 7) != 0);
      r_data_i  = {$random(seed), $random(seed), $random(seed), $random(seed)};
      for (int l = 0; l < `VLDU_NR_LANES; l++) begin
        k = wr_cnt[l];
        // Stalled loads get a grant one cycle in four
        if (lane_req_o[l] && k < total_words && rows[exp_row[k]].stall) begin
          lane_gnt_i[l] = (($random(seed) & 3) == 0);
        end else begin
          lane_gnt_i[l] = lane_req_o[l];
        end
      end
    end
  end

  initial begin : main
    int waited;
    seed         = 32'h4623793e;
    rst_ni       = 1'b0;
    insn_i       = '0;
    insn_valid_i = 1'b0;
    r_data_i     = '0;
    r_valid_i    = 1'b0;
    lane_gnt_i   = '0;
    stim_on      = 1'b0;
    saw_full     = 1'b0;
    aborted      = 1'b0;
    beat_cnt     = 0;
    done_cnt     = 0;
    err_cnt      = 0;
    chk_cnt      = 0;
    for (int l = 0; l < `VLDU_NR_LANES; l++) begin
      wr_cnt[l] = 0;
    end
    load_table();
    build_expected();

    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni    = 1'b1;
    // Beat offered but no load yet, so nothing may be taken
    r_valid_i = 1'b1;
    @(posedge clk_i);
    check_value("reset insn_ready_o", 64'(1), 64'(insn_ready_o));
    check_value("reset r_ready_o", 64'(0), 64'(r_ready_o));
    check_value("reset lane_req_o", 64'(0), 64'(lane_req_o));
    check_value("reset done_o", 64'(0), 64'(done_o));
    stim_on = 1'b1;

    for (int r = 0; r < NR_ROWS; r++) begin
      if (!aborted) begin
        offer_insn(r);
      end
    end
    @(negedge clk_i);
    insn_valid_i = 1'b0;

    waited = 0;
    while (!aborted && done_cnt < NR_ROWS && waited < DONE_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!aborted && done_cnt < NR_ROWS) begin
      report_failure($sformatf("timeout: only %0d of %0d loads reported done",
                               done_cnt, NR_ROWS));
    end

    // Short quiet period to catch stray writes or done pulses
    repeat (8) @(negedge clk_i);
    check_value("beats consumed", 64'(total_words), 64'(beat_cnt));
    for (int l = 0; l < `VLDU_NR_LANES; l++) begin
      check_value($sformatf("lane%0d writes", l), 64'(total_words), 64'(wr_cnt[l]));
    end
    check_value("insn_ready_o fell with four loads in flight", 64'(1), 64'(saw_full));

    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+verilog
verilog/vldu_pkg.sv
verilog/vldu_insn_queue.sv
verilog/vldu_beat_unpack.sv
verilog/vldu_result_queue.sv
verilog/vldu_top.sv
verif/vldu_properties.sv
verif/tb_vldu.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_vldu \
  -o sim_vldu > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_vldu > sim.log 2>&1
cat sim.log
grep -q "^NO ERRORS$" sim.log && echo "Simulation passed" || {
  echo "Simulation failed, see sim.log"
  exit 1
}
